/* source/sprite_defines.svh */
/*
  Size constants for the sprite line renderer
  Slot count, pixels per line, pattern row width
*/
`ifndef SPRITE_DEFINES_SVH
`define SPRITE_DEFINES_SVH

// Sprite shifters in the chain, as many as one scanline may show
`define SPRITE_SLOTS 8

// Visible pixels per scanline
`define LINE_PIXELS 256

// Bits in one pattern row, one per pixel
`define PATTERN_BITS 8

`endif

/* source/sprite_pkg.sv */
/*
  Shared vector types and loader FSM encoding for the sprite renderer
*/
`default_nettype none

`include "sprite_defines.svh"

package sprite_pkg;

  typedef logic [`PATTERN_BITS-1:0] pattern_t;  // One pattern row, leftmost pixel first after load
  typedef logic [7:0]               xpos_t;     // Pixel column or sprite X
  typedef logic [1:0]               palette_t;  // Sprite palette select
  typedef logic [1:0]               color_bits_t; // Pattern color, zero is transparent

  // Slot output as {priority, palette[1:0], color[1:0]}
  typedef logic [4:0]               slot_pixel_t;

  typedef logic [3:0]               slot_count_t; // Filled slots, 0 to 8

  // Line phases of the loader
  typedef enum logic [1:0] {
    LOAD, // Taking records
    PAD,  // Filling empty slots with transparent sprites
    DRAW  // Shifters being drained by the mux
  } loader_state_t;

endpackage

`default_nettype wire

/* source/sprite_slot_if.sv */
/*
  One link of the sprite record chain, record plus shift strobe
*/
`timescale 1ns/1ps
`default_nettype none

interface sprite_slot_if;

  logic                  shift;      // Move every record one slot toward slot 0
  sprite_pkg::pattern_t  pattern_lo; // Color bit 0 row, LSB shown first
  sprite_pkg::pattern_t  pattern_hi; // Color bit 1 row
  sprite_pkg::xpos_t     x;          // Start column
  sprite_pkg::palette_t  palette;
  logic                  prio;       // Behind-background flag, passed through to the pixel

  // Side that sends the record
  modport upstream (
    output shift, pattern_lo, pattern_hi, x, palette, prio
  );

  // Side that takes the record
  modport downstream (
    input shift, pattern_lo, pattern_hi, x, palette, prio
  );

endinterface

`default_nettype wire

/* source/sprite_loader.sv */
/*
  Sprite record intake with flip handling, slot counting and padding
  Line phase FSM between loading and drawing
*/
`timescale 1ns/1ps
`default_nettype none

`include "sprite_defines.svh"

module sprite_loader (
  input  wire logic                 clk,
  input  wire logic                 reset,
  input  wire logic                 rec_valid,
  output logic                      rec_ready,
  input  wire logic                 rec_last,       // Final record of this line
  input  wire sprite_pkg::pattern_t rec_pattern_lo,
  input  wire sprite_pkg::pattern_t rec_pattern_hi,
  input  wire sprite_pkg::xpos_t    rec_x,
  input  wire sprite_pkg::palette_t rec_palette,
  input  wire logic                 rec_priority,
  input  wire logic                 rec_flip_x,
  sprite_slot_if.upstream           chain,          // Feeds the top of the shifter chain
  output logic                      draw,
  input  wire logic                 line_done       // 256th pixel taken into the mux register
);

  import sprite_pkg::*;

  localparam slot_count_t SLOTS_FULL = slot_count_t'(`SPRITE_SLOTS);
  localparam slot_count_t SLOTS_LAST = slot_count_t'(`SPRITE_SLOTS - 1);

  loader_state_t state;
  slot_count_t   fill_cnt;   // Shifts done this line
  logic          rec_take;   // Record handshake
  logic          room;       // Chain not yet full
  logic          shift_now;
  logic          line_full;  // All slots filled after this cycle
  pattern_t      lo_ordered;
  pattern_t      hi_ordered;

  // Mirror a pattern row so its leftmost pixel lands in bit 0
  function automatic pattern_t reverse_bits(input pattern_t value);
    pattern_t result;
    for (int i = 0; i < `PATTERN_BITS; i++) begin
      result[i] = value[`PATTERN_BITS-1-i];
    end
    return result;
  endfunction

  assign rec_ready = (state == LOAD);
  assign draw      = (state == DRAW);
  assign rec_take  = rec_valid && rec_ready;
  assign room      = (fill_cnt != SLOTS_FULL); // Beyond eight, records are dropped

  // Real record while there is room, or a blank one while padding
  assign shift_now = (rec_take && room) || (state == PAD);
  assign line_full = (fill_cnt == SLOTS_FULL) || (shift_now && fill_cnt == SLOTS_LAST);

  // Unflipped rows come MSB-left, so turn them around
  assign lo_ordered = rec_flip_x ? rec_pattern_lo : reverse_bits(rec_pattern_lo);
  assign hi_ordered = rec_flip_x ? rec_pattern_hi : reverse_bits(rec_pattern_hi);

  // Padding sprites are all transparent
  assign chain.shift      = shift_now;
  assign chain.pattern_lo = (state == PAD) ? '0 : lo_ordered;
  assign chain.pattern_hi = (state == PAD) ? '0 : hi_ordered;
  assign chain.x          = (state == PAD) ? '0 : rec_x;
  assign chain.palette    = (state == PAD) ? '0 : rec_palette;
  assign chain.prio       = (state == PAD) ? 1'b0 : rec_priority;

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= LOAD;
      fill_cnt <= '0;
    end else begin
      if (shift_now)
        fill_cnt <= fill_cnt + 1'b1;
      case (state)
        LOAD: begin
          // Short list goes through PAD, a full one straight to DRAW
          if (rec_take && rec_last)
            state <= line_full ? DRAW : PAD;
        end
        PAD: begin
          if (line_full)
            state <= DRAW;
        end
        DRAW: begin
          if (line_done) begin
            state    <= LOAD; // Next line may load while last pixel waits
            fill_cnt <= '0;
          end
        end
        default: state <= LOAD;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/sprite_shifter.sv */
/*
  One sprite slot: X countdown, pattern shift registers, attributes
*/
`timescale 1ns/1ps
`default_nettype none

module sprite_shifter (
  input  wire logic         clk,
  sprite_slot_if.downstream upstream,   // Record from the slot above
  sprite_slot_if.upstream   downstream, // Old record to the slot below
  input  wire logic         advance,    // One pixel column consumed
  output sprite_pkg::slot_pixel_t pixel
);

  import sprite_pkg::*;

  pattern_t    pat_lo;
  pattern_t    pat_hi;
  xpos_t       x_cnt;   // Columns left before the sprite starts
  palette_t    palette;
  logic        prio;
  logic        active;
  color_bits_t color;

  always_ff @(posedge clk) begin
    if (upstream.shift) begin
      pat_lo  <= upstream.pattern_lo;
      pat_hi  <= upstream.pattern_hi;
      x_cnt   <= upstream.x;
      palette <= upstream.palette;
      prio    <= upstream.prio;
    end else if (advance) begin
      if (!active) begin
        x_cnt <= x_cnt - 1'b1;
      end else begin
        // Zero fill, so the sprite turns transparent after eight pixels
        pat_lo <= pat_lo >> 1;
        pat_hi <= pat_hi >> 1;
      end
    end
  end

  assign active = (x_cnt == '0);
  assign color  = active ? {pat_hi[0], pat_lo[0]} : 2'b00;
  assign pixel  = {prio, palette, color};

  // Shift strobe ripples down unchanged, data is the registered copy
  assign downstream.shift      = upstream.shift;
  assign downstream.pattern_lo = pat_lo;
  assign downstream.pattern_hi = pat_hi;
  assign downstream.x          = x_cnt;
  assign downstream.palette    = palette;
  assign downstream.prio       = prio;

endmodule

`default_nettype wire

/* source/sprite_priority_mux.sv */
/*
  Sprite slot priority select and pixel output register with valid/ready
  Column counter marks the last pixel of the line
*/
`timescale 1ns/1ps
`default_nettype none

`include "sprite_defines.svh"

module sprite_priority_mux (
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire sprite_pkg::slot_pixel_t slot_pixels [`SPRITE_SLOTS],
  input  wire logic                    draw,
  output logic                         advance,     // Step all shifters one column
  output logic                         line_done,
  output logic                         pix_valid,
  input  wire logic                    pix_ready,
  output sprite_pkg::color_bits_t      pix_color,
  output sprite_pkg::palette_t         pix_palette,
  output logic                         pix_priority,
  output logic                         pix_sprite0,
  output logic                         pix_last
);

  import sprite_pkg::*;

  localparam xpos_t LAST_COL = xpos_t'(`LINE_PIXELS - 1);

  slot_pixel_t sel;       // Winning slot this column
  logic        sel_zero;  // Slot 0 opaque
  logic        last_col;
  xpos_t       col;       // Column being loaded next

  // Walk from the top so the lowest opaque slot wins, slot 7 if none
  always_comb begin
    sel = slot_pixels[`SPRITE_SLOTS-1];
    for (int i = `SPRITE_SLOTS - 1; i >= 0; i--) begin
      if (slot_pixels[i][1:0] != 2'b00)
        sel = slot_pixels[i];
    end
  end

  assign sel_zero = (slot_pixels[0][1:0] != 2'b00);
  assign last_col = (col == LAST_COL);

  // Load when the register is empty or its pixel leaves this cycle
  assign advance   = draw && (!pix_valid || pix_ready);
  assign line_done = advance && last_col;

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_valid <= 1'b0;
      col       <= '0;
    end else begin
      if (advance) begin
        pix_valid <= 1'b1;
        col       <= col + 1'b1; // Wraps to 0 after the last column
      end else if (pix_ready) begin
        pix_valid <= 1'b0;
      end
    end
  end

  // Pixel data, held while pix_ready is low
  always_ff @(posedge clk) begin
    if (advance) begin
      pix_priority <= sel[4];
      pix_palette  <= sel[3:2];
      pix_color    <= sel[1:0];
      pix_sprite0  <= sel_zero;
      pix_last     <= last_col;
    end
  end

endmodule

`default_nettype wire

/* source/sprite_line_renderer.sv */
/*
  Sprite line renderer top: loader, chain of sprite shifters, priority mux
*/
`timescale 1ns/1ps
`default_nettype none

`include "sprite_defines.svh"

module sprite_line_renderer (
  input  wire logic                 clk,
  input  wire logic                 reset,
  // Sprite record stream
  input  wire logic                 rec_valid,
  output logic                      rec_ready,
  input  wire logic                 rec_last,
  input  wire sprite_pkg::pattern_t rec_pattern_lo,
  input  wire sprite_pkg::pattern_t rec_pattern_hi,
  input  wire sprite_pkg::xpos_t    rec_x,
  input  wire sprite_pkg::palette_t rec_palette,
  input  wire logic                 rec_priority,
  input  wire logic                 rec_flip_x,
  // Pixel stream
  output logic                      pix_valid,
  input  wire logic                 pix_ready,
  output sprite_pkg::color_bits_t   pix_color,
  output sprite_pkg::palette_t      pix_palette,
  output logic                      pix_priority,
  output logic                      pix_sprite0,
  output logic                      pix_last
);

  import sprite_pkg::*;

  logic        draw;
  logic        advance;
  logic        line_done;
  slot_pixel_t slot_pixels [`SPRITE_SLOTS];

  // Link k feeds shifter k-1, link 8 comes from the loader, link 0 ends the chain
  sprite_slot_if link [`SPRITE_SLOTS+1] ();

  sprite_loader sprite_loader_i (
    .clk            (clk),
    .reset          (reset),
    .rec_valid      (rec_valid),
    .rec_ready      (rec_ready),
    .rec_last       (rec_last),
    .rec_pattern_lo (rec_pattern_lo),
    .rec_pattern_hi (rec_pattern_hi),
    .rec_x          (rec_x),
    .rec_palette    (rec_palette),
    .rec_priority   (rec_priority),
    .rec_flip_x     (rec_flip_x),
    .chain          (link[`SPRITE_SLOTS]),
    .draw           (draw),
    .line_done      (line_done)
  );

  for (genvar k = 0; k < `SPRITE_SLOTS; k++) begin : g_slot
    sprite_shifter sprite_shifter_i (
      .clk        (clk),
      .upstream   (link[k+1]),
      .downstream (link[k]),
      .advance    (advance),
      .pixel      (slot_pixels[k])
    );
  end

  sprite_priority_mux sprite_priority_mux_i (
    .clk          (clk),
    .reset        (reset),
    .slot_pixels  (slot_pixels),
    .draw         (draw),
    .advance      (advance),
    .line_done    (line_done),
    .pix_valid    (pix_valid),
    .pix_ready    (pix_ready),
    .pix_color    (pix_color),
    .pix_palette  (pix_palette),
    .pix_priority (pix_priority),
    .pix_sprite0  (pix_sprite0),
    .pix_last     (pix_last)
  );

endmodule

`default_nettype wire

/* tb/tb_sprite_line_renderer.sv */
/*
  Testbench for the sprite line renderer
  Random sprite lists, per-line reference model, handshake checks, watchdog
*/
`timescale 1ns/1ps
`default_nettype none

`include "sprite_defines.svh"

module tb_sprite_line_renderer;

  localparam int SEED      = 58;
  localparam int LINES     = 40;
  localparam int MAX_RECS  = 11;  // Up to three records beyond the slot count
  localparam int STALL_PCT = 30;  // Chance of pix_ready low per cycle
  localparam int TOTAL_PIX = LINES * `LINE_PIXELS;

  logic       clk = 1'b0;
  logic       reset;
  logic       rec_valid;
  logic       rec_ready;
  logic       rec_last;
  logic [7:0] rec_pattern_lo;
  logic [7:0] rec_pattern_hi;
  logic [7:0] rec_x;
  logic [1:0] rec_palette;
  logic       rec_priority;
  logic       rec_flip_x;
  logic       pix_valid;
  logic       pix_ready;
  logic [1:0] pix_color;
  logic [1:0] pix_palette;
  logic       pix_priority;
  logic       pix_sprite0;
  logic       pix_last;

  // Records of the line being sent
  logic [7:0] r_lo   [MAX_RECS];
  logic [7:0] r_hi   [MAX_RECS];
  logic [7:0] r_x    [MAX_RECS];
  logic [1:0] r_pal  [MAX_RECS];
  logic       r_pri  [MAX_RECS];
  logic       r_flip [MAX_RECS];

  logic [5:0] exp_q [$];  // {sprite0, priority, palette, color} per pixel
  int         errors = 0;
  int         pixels = 0;

  sprite_line_renderer sprite_line_renderer_i (
    .clk (clk), .reset (reset),
    .rec_valid (rec_valid), .rec_ready (rec_ready), .rec_last (rec_last),
    .rec_pattern_lo (rec_pattern_lo), .rec_pattern_hi (rec_pattern_hi),
    .rec_x (rec_x), .rec_palette (rec_palette), .rec_priority (rec_priority),
    .rec_flip_x (rec_flip_x),
    .pix_valid (pix_valid), .pix_ready (pix_ready), .pix_color (pix_color),
    .pix_palette (pix_palette), .pix_priority (pix_priority),
    .pix_sprite0 (pix_sprite0), .pix_last (pix_last)
  );

  always #50 clk = ~clk;  // 100 ns period

  // Reference pixel for column c from the first kept records
  function automatic logic [5:0] model_pixel(input int c, input int kept);
    logic [5:0] res;
    logic [1:0] color;
    logic       found;
    int         i;
    int         b;
    res   = '0;
    found = 1'b0;
    for (int j = 0; j < kept; j++) begin
      i = c - int'(r_x[j]);
      if (i >= 0 && i <= 7) begin
        b     = r_flip[j] ? i : 7 - i;  // Unflipped rows start at bit 7
        color = {r_hi[j][b], r_lo[j][b]};
        if (j == 0 && color != 2'b00)
          res[5] = 1'b1;
        if (!found && color != 2'b00) begin
          res[4:0] = {r_pri[j], r_pal[j], color};  // Earliest opaque record wins
          found    = 1'b1;
        end
      end
    end
    return res;
  endfunction

  task automatic check_idle(input string when);
    if (pix_valid !== 1'b0 || rec_ready !== 1'b1) begin
      $display("[FAIL] %0t: %s pix_valid=%b rec_ready=%b", $time, when, pix_valid, rec_ready);
      errors++;
    end
  endtask

  task automatic send_lines();
    int n;
    int j;
    for (int line = 0; line < LINES; line++) begin
      n = 1 + int'($urandom % MAX_RECS);
      for (int k = 0; k < n; k++) begin
        r_lo[k]   = 8'($urandom);
        r_hi[k]   = 8'($urandom);
        r_x[k]    = ($urandom % 4 == 0) ? 8'(248 + $urandom % 8) : 8'($urandom);  // Edge bias
        r_pal[k]  = 2'($urandom);
        r_pri[k]  = 1'($urandom);
        r_flip[k] = 1'($urandom);
      end
      for (int c = 0; c < `LINE_PIXELS; c++)
        exp_q.push_back(model_pixel(c, (n < `SPRITE_SLOTS) ? n : `SPRITE_SLOTS));
      j = 0;
      while (j < n) begin
        @(negedge clk);
        if ($urandom % 4 == 0) begin
          rec_valid = 1'b0;  // Random gap
        end else begin
          rec_valid      = 1'b1;
          rec_last       = (j == n - 1);
          rec_pattern_lo = r_lo[j];
          rec_pattern_hi = r_hi[j];
          rec_x          = r_x[j];
          rec_palette    = r_pal[j];
          rec_priority   = r_pri[j];
          rec_flip_x     = r_flip[j];
        end
        if (rec_valid && rec_ready)  // rec_ready holds until the next rising edge
          j++;
      end
    end
    @(negedge clk);
    rec_valid = 1'b0;
  endtask

  task automatic take_pixels();
    logic [6:0] held;
    logic [6:0] now;
    logic [5:0] exp;
    logic       waiting;
    int         col;
    waiting = 1'b0;
    col     = 0;
    while (pixels < TOTAL_PIX) begin
      @(negedge clk);
      now = {pix_last, pix_sprite0, pix_priority, pix_palette, pix_color};
      if (waiting && !pix_valid) begin
        $display("[FAIL] %0t: pix_valid dropped before the pixel was taken", $time);
        errors++;
      end else if (waiting && now !== held) begin
        $display("[FAIL] %0t: pixel data changed while stalled %h -> %h", $time, held, now);
        errors++;
      end
      pix_ready = (($urandom % 100) >= STALL_PCT);
      if (pix_valid && pix_ready) begin
        exp = exp_q.pop_front();
        if (pix_color !== exp[1:0]) begin
          $display("[FAIL] %0t: column %0d color %0d, expected %0d",
                   $time, col, pix_color, exp[1:0]);
          errors++;
        end else if (exp[1:0] != 2'b00 && {pix_priority, pix_palette} !== exp[4:2]) begin
          $display("[FAIL] %0t: column %0d prio/palette %b, expected %b",
                   $time, col, {pix_priority, pix_palette}, exp[4:2]);
          errors++;
        end
        if (pix_sprite0 !== exp[5]) begin
          $display("[FAIL] %0t: column %0d sprite0 %b, expected %b",
                   $time, col, pix_sprite0, exp[5]);
          errors++;
        end
        if (pix_last !== (col == `LINE_PIXELS - 1)) begin
          $display("[FAIL] %0t: column %0d pix_last %b", $time, col, pix_last);
          errors++;
        end
        pixels++;
        col = (col == `LINE_PIXELS - 1) ? 0 : col + 1;
      end
      waiting = pix_valid && !pix_ready;
      held    = now;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    reset = 1'b1;
    rec_valid = 1'b0;
    rec_last = 1'b0;
    rec_pattern_lo = '0;
    rec_pattern_hi = '0;
    rec_x = '0;
    rec_palette = '0;
    rec_priority = 1'b0;
    rec_flip_x = 1'b0;
    pix_ready = 1'b0;
    for (int k = 0; k < 16; k++) begin
      @(negedge clk);
      if (k > 0)
        check_idle("in reset");  // State is known after the first edge
    end
    reset = 1'b0;
    @(negedge clk);
    check_idle("after reset");
    fork
      send_lines();
      take_pixels();
    join
    $display("Summary: %0d lines, %0d pixels checked, %0d errors", LINES, pixels, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  // Ends a hung run, records or pixels stuck
  initial begin
    repeat (LINES * 1500 + 100) @(posedge clk);
    $display("Timeout: only %0d of %0d pixels arrived", pixels, TOTAL_PIX);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
+incdir+source
source/sprite_pkg.sv
source/sprite_slot_if.sv
source/sprite_loader.sv
source/sprite_shifter.sv
source/sprite_priority_mux.sv
source/sprite_line_renderer.sv
tb/tb_sprite_line_renderer.sv

/* run.sh */
#!/bin/sh
# Build the sprite line renderer testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f tb.f --top-module tb_sprite_line_renderer
output=$(./obj_dir/Vtb_sprite_line_renderer)
echo "$output"
if echo "$output" | grep -q "^PASS: all tests$"; then
  exit 0
fi
exit 1
